/* design/vdma_pkg.sv */
// shared widths, burst constants and vector types of the video frame writer, imported by RTL and testbench
package vdma_pkg;

    // pixel and bus geometry
    localparam int PIXEL_W         = 32;
    localparam int PIXELS_PER_BEAT = 4;
    localparam int BEAT_W          = 128;
    // address step per beat, 16-byte INCR beats
    localparam int BEAT_BYTES      = 16;
    localparam int ADDR_W          = 32;

    // normal burst length in beats
    // also the fill level the FSM waits for before a full burst
    localparam int BURST_BEATS     = 8;

    // beat FIFO sizing
    localparam int FIFO_DEPTH      = 32;
    // fill level where the video source should back off
    localparam int FIFO_AFULL      = 24;

    // one video pixel
    typedef logic [PIXEL_W-1:0] pixel_t;

    // four pixels, first pixel in the low bits
    typedef logic [BEAT_W-1:0] beat_t;

    // AXI byte address
    typedef logic [ADDR_W-1:0] addr_t;

    // hactive / vactive
    typedef logic [15:0] dim_t;

    // beats per frame or beats still owed
    typedef logic [15:0] beat_count_t;

    // FIFO fill count, 0 to FIFO_DEPTH inclusive
    typedef logic [5:0] fifo_count_t;

    // awlen field and burst beat counts
    typedef logic [7:0] burst_len_t;

    // write FSM
    // IDLE waits for data, ADDR drives AW, DATA drives W, RESP waits for B
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        RESP
    } wr_state_t;

endpackage

/* design/pixel_packer.sv */
// accepts a video frame at its vsync rise and packs four native pixels into each bus beat
`timescale 1ns/1ps

module pixel_packer import vdma_pkg::*; (
    input  logic   axi_aclk,
    input  logic   reset,
    input  logic   enable,
    input  logic   frame_idle,
    input  logic   vsync,
    input  logic   de,
    input  pixel_t pixel,
    output logic   frame_start,
    output logic   beat_push,
    output beat_t  beat_data
);

    logic       vsync_d;
    logic       vsync_rise;
    logic       frame_active;
    logic [1:0] slot;
    logic       take_pixel;

    // vsync edge detect
    assign vsync_rise = vsync && !vsync_d;

    // pixels only count inside an accepted frame
    assign take_pixel = de && frame_active;

    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            vsync_d      <= 1'b0;
            frame_active <= 1'b0;
            frame_start  <= 1'b0;
            slot         <= 2'd0;
            beat_push    <= 1'b0;
        end else begin
            vsync_d     <= vsync;
            // accept only when enabled and the previous frame is fully written
            frame_start <= vsync_rise && enable && frame_idle;
            beat_push   <= take_pixel && (slot == 2'd3);
            if (vsync_rise) begin
                // a refused frame drops every pixel up to the next vsync
                frame_active <= enable && frame_idle;
                slot         <= 2'd0;
            end else if (take_pixel) begin
                // wraps after the fourth pixel of a group
                slot <= slot + 2'd1;
            end
        end
    end

    // shift down so the first pixel of a group ends in the lowest bits
    always_ff @(posedge axi_aclk) begin
        if (take_pixel) begin
            beat_data <= {pixel, beat_data[BEAT_W-1:PIXEL_W]};
        end
    end

endmodule

/* design/beat_fifo.sv */
// synchronous show-ahead FIFO of packed beats between the pixel packer and the AXI W channel
`timescale 1ns/1ps

module beat_fifo import vdma_pkg::*; (
    input  logic        axi_aclk,
    input  logic        reset,
    input  logic        push,
    input  beat_t       push_data,
    input  logic        pop,
    output beat_t       head_data,
    output fifo_count_t fifo_count,
    output logic        almost_full
);

    // beat storage
    beat_t mem [FIFO_DEPTH];

    // depth is a power of two so the pointers wrap freely
    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;

    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // show-ahead head is valid whenever the count is non-zero
    assign head_data = mem[rd_ptr];

    // back-pressure level for the video source
    assign almost_full = (fifo_count >= fifo_count_t'(FIFO_AFULL));

    // video has no stall so a full FIFO means the bus fell too far behind
    a_no_overflow : assert property (@(posedge axi_aclk) disable iff (reset)
        push |-> (fifo_count != fifo_count_t'(FIFO_DEPTH)) || pop);

    // the FSM only pops beats it saw buffered
    a_no_underflow : assert property (@(posedge axi_aclk) disable iff (reset)
        pop |-> (fifo_count != '0));

endmodule

/* design/frame_burst_tracker.sv */
// keeps the beats still owed for the current frame and the address of the next burst
`timescale 1ns/1ps

module frame_burst_tracker import vdma_pkg::*; (
    input  logic        axi_aclk,
    input  logic        reset,
    input  logic        frame_start,
    input  addr_t       baseaddr,
    input  dim_t        hactive,
    input  dim_t        vactive,
    input  logic        burst_done,
    input  burst_len_t  burst_beats,
    output beat_count_t beats_left,
    output addr_t       burst_addr
);

    logic [31:0] frame_pixels;
    beat_count_t frame_beats;
    beat_count_t done_beats;
    addr_t       done_bytes;

    // frame pixel total is always a multiple of four
    assign frame_pixels = 32'(hactive) * 32'(vactive);
    assign frame_beats  = beat_count_t'(frame_pixels / PIXELS_PER_BEAT);

    // the finished burst in beats and in bytes
    assign done_beats = beat_count_t'(burst_beats);
    assign done_bytes = addr_t'(burst_beats) * addr_t'(BEAT_BYTES);

    // zero owed beats means idle and ready for a new frame
    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            beats_left <= '0;
        end else if (frame_start) begin
            beats_left <= frame_beats;
        end else if (burst_done) begin
            beats_left <= beats_left - done_beats;
        end
    end

    // next burst address steps past each finished burst
    always_ff @(posedge axi_aclk) begin
        if (frame_start) begin
            burst_addr <= baseaddr;
        end else if (burst_done) begin
            burst_addr <= burst_addr + done_bytes;
        end
    end

    // FSM must never write past the end of the frame
    a_burst_fits : assert property (@(posedge axi_aclk) disable iff (reset)
        burst_done |-> (done_beats <= beats_left));

    // a new frame only starts once the old one is fully written
    a_start_idle : assert property (@(posedge axi_aclk) disable iff (reset)
        frame_start |-> (beats_left == '0) && !burst_done);

endmodule

/* design/axi_write_fsm.sv */
// AXI4 write master FSM issuing full or tail bursts from buffered beats with one burst in flight
`timescale 1ns/1ps

module axi_write_fsm import vdma_pkg::*; (
    input  logic        axi_aclk,
    input  logic        reset,
    input  beat_count_t beats_left,
    input  fifo_count_t fifo_count,
    input  addr_t       burst_addr,
    output addr_t       awaddr,
    output burst_len_t  awlen,
    output logic        awvalid,
    input  logic        awready,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    output logic        fifo_pop,
    output logic        burst_done,
    output burst_len_t  burst_beats
);

    wr_state_t  state;
    burst_len_t beat_cnt;
    burst_len_t len_beats;
    burst_len_t next_len;
    logic       start_burst;
    logic       start_tail;

    // full burst when the frame still owes at least one and the FIFO holds it
    assign start_burst = (beats_left >= beat_count_t'(BURST_BEATS))
                      && (fifo_count >= fifo_count_t'(BURST_BEATS));

    // tail when fewer than a burst is owed and all of it is buffered
    assign start_tail = (beats_left != '0)
                     && (beats_left < beat_count_t'(BURST_BEATS))
                     && (beat_count_t'(fifo_count) >= beats_left);

    // tail length fits awlen since it is below BURST_BEATS
    assign next_len = start_burst ? burst_len_t'(BURST_BEATS) : burst_len_t'(beats_left);

    // channel handshakes follow the state directly
    assign awvalid = (state == ADDR);
    // data is already buffered so W only waits on wready
    assign wvalid  = (state == DATA);
    assign bready  = (state == RESP);

    assign wlast    = wvalid && (beat_cnt == awlen);
    assign fifo_pop = wvalid && wready;

    // tracker update on the B handshake
    assign burst_done  = bready && bvalid;
    assign burst_beats = len_beats;

    always_ff @(posedge axi_aclk) begin
        if (reset) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_burst || start_tail) begin
                        state <= ADDR;
                    end
                end
                ADDR: begin
                    if (awready) begin
                        state    <= DATA;
                        beat_cnt <= '0;
                    end
                end
                DATA: begin
                    if (fifo_pop) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) begin
                            state <= RESP;
                        end
                    end
                end
                RESP: begin
                    if (bvalid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // burst address and length latch at the decision
    always_ff @(posedge axi_aclk) begin
        if (state == IDLE && (start_burst || start_tail)) begin
            awaddr    <= burst_addr;
            awlen     <= next_len - 1'b1;
            len_beats <= next_len;
        end
    end

    // AW request held steady until accepted
    a_aw_stable : assert property (@(posedge axi_aclk) disable iff (reset)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));

    // wlast lands on the beat that completes the length handed to the tracker
    a_wlast_ends : assert property (@(posedge axi_aclk) disable iff (reset)
        fifo_pop |-> (wlast == (beat_cnt + 1'b1 == len_beats)));

    // the FIFO head is real data for every W beat offered
    a_w_buffered : assert property (@(posedge axi_aclk) disable iff (reset)
        wvalid |-> (fifo_count != '0));

endmodule

/* design/vdma_write_top.sv */
// video frame writer top, native video in and AXI4 write bursts out on one clock
`timescale 1ns/1ps

module vdma_write_top import vdma_pkg::*; (
    input  logic       axi_aclk,
    input  logic       reset,
    // configuration, sampled at frame start
    input  logic       enable,
    input  addr_t      baseaddr,
    input  dim_t       hactive,
    input  dim_t       vactive,
    // native video
    input  logic       vsync,
    input  logic       de,
    input  pixel_t     pixel,
    // AXI write address
    output addr_t      awaddr,
    output burst_len_t awlen,
    output logic       awvalid,
    input  logic       awready,
    // AXI write data
    output beat_t      wdata,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    // AXI write response
    input  logic       bvalid,
    output logic       bready,
    output logic       fifo_almost_full
);

    logic        frame_start;
    logic        frame_idle;
    logic        beat_push;
    beat_t       beat_data;
    logic        fifo_pop;
    fifo_count_t fifo_count;
    beat_count_t beats_left;
    addr_t       burst_addr;
    logic        burst_done;
    burst_len_t  burst_beats;

    // nothing owed means the writer can take a new frame
    assign frame_idle = (beats_left == '0);

    pixel_packer packer_i (
        .axi_aclk    (axi_aclk),
        .reset       (reset),
        .enable      (enable),
        .frame_idle  (frame_idle),
        .vsync       (vsync),
        .de          (de),
        .pixel       (pixel),
        .frame_start (frame_start),
        .beat_push   (beat_push),
        .beat_data   (beat_data)
    );

    // head of the FIFO feeds wdata directly
    beat_fifo fifo_i (
        .axi_aclk    (axi_aclk),
        .reset       (reset),
        .push        (beat_push),
        .push_data   (beat_data),
        .pop         (fifo_pop),
        .head_data   (wdata),
        .fifo_count  (fifo_count),
        .almost_full (fifo_almost_full)
    );

    frame_burst_tracker tracker_i (
        .axi_aclk    (axi_aclk),
        .reset       (reset),
        .frame_start (frame_start),
        .baseaddr    (baseaddr),
        .hactive     (hactive),
        .vactive     (vactive),
        .burst_done  (burst_done),
        .burst_beats (burst_beats),
        .beats_left  (beats_left),
        .burst_addr  (burst_addr)
    );

    axi_write_fsm fsm_i (
        .axi_aclk    (axi_aclk),
        .reset       (reset),
        .beats_left  (beats_left),
        .fifo_count  (fifo_count),
        .burst_addr  (burst_addr),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .awvalid     (awvalid),
        .awready     (awready),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready),
        .fifo_pop    (fifo_pop),
        .burst_done  (burst_done),
        .burst_beats (burst_beats)
    );

endmodule

/* sim/tb_vdma_write.sv */
// directed testbench for the video frame writer, with video driver, AXI slave memory model and stalls
`timescale 1ns/1ps

module tb_vdma_write import vdma_pkg::*; ();

    localparam logic [31:0] LFSR_SEED = 32'h9db6f980;
    // five short frames of at most a few hundred cycles each, even with stalls
    localparam int MAX_CYCLES = 20000;

    logic       axi_aclk;
    logic       reset;
    logic       enable;
    addr_t      baseaddr;
    dim_t       hactive;
    dim_t       vactive;
    logic       vsync;
    logic       de;
    pixel_t     pixel;
    addr_t      awaddr;
    burst_len_t awlen;
    logic       awvalid;
    logic       awready = 1'b0;
    beat_t      wdata;
    logic       wlast;
    logic       wvalid;
    logic       wready = 1'b0;
    logic       bvalid = 1'b0;
    logic       bready;
    logic       fifo_almost_full;

    // slave model state
    addr_t      aw_addr_q[$];
    burst_len_t aw_len_q[$];
    beat_t      mem[addr_t];
    addr_t      w_addr;
    int         w_beats;
    logic       b_pending = 1'b0;
    int         b_count = 0;
    logic       stall_on = 1'b0;
    logic       afull_seen = 1'b0;

    // stimulus and bookkeeping
    pixel_t      exp_pix[$];
    logic [31:0] pix_lfsr = LFSR_SEED;
    logic [31:0] stall_lfsr = LFSR_SEED;
    int          errors = 0;
    int          err_mark = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;

    vdma_write_top dut_i (.*);

    initial begin
        axi_aclk = 1'b0;
        forever #50 axi_aclk = ~axi_aclk;
    end

    // galois right shift, taps 32 30 26 25
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end
        return s >> 1;
    endfunction

    // one step per pixel bit
    function automatic pixel_t random_pixel();
        pixel_t p;
        for (int i = 0; i < PIXEL_W; i++) begin
            pix_lfsr = lfsr_step(pix_lfsr);
            p[i]     = pix_lfsr[0];
        end
        return p;
    endfunction

    function automatic logic stall_bit();
        stall_lfsr = lfsr_step(stall_lfsr);
        return stall_lfsr[0];
    endfunction

    function automatic int bursts_for(input int beats);
        return (beats + BURST_BEATS - 1) / BURST_BEATS;
    endfunction

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_len(input string what, input burst_len_t got, input burst_len_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_beat(input string what, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s 0x%032h, expected 0x%032h", $time, what, got, exp);
        end
    endtask

    // slave readies and response, driven on the falling edge
    always @(negedge axi_aclk) begin
        if (stall_on) begin
            awready = stall_bit();
            wready  = stall_bit();
        end else begin
            awready = 1'b1;
            wready  = 1'b1;
        end
        bvalid = b_pending;
    end

    // handshakes seen at the rising edge, values stable since the falling edge
    always @(posedge axi_aclk) begin
        if (fifo_almost_full) begin
            afull_seen = 1'b1;
        end
        if (awvalid && awready) begin
            aw_addr_q.push_back(awaddr);
            aw_len_q.push_back(awlen);
            w_addr  = awaddr;
            w_beats = 0;
        end
        if (wvalid && wready) begin
            mem[w_addr] = wdata;
            w_addr      = w_addr + addr_t'(BEAT_BYTES);
            if (wlast) begin
                // wlast only on the beat that awlen names
                check_len("wlast at beat", burst_len_t'(w_beats), aw_len_q[$]);
                b_pending = 1'b1;
            end
            w_beats++;
        end
        if (bvalid && bready) begin
            b_pending = 1'b0;
            b_count++;
        end
    end

    // run limit
    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge axi_aclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // vsync pulse, short blank, then v lines of h pixels with a short hblank
    task automatic send_frame(input dim_t h, input dim_t v);
        @(negedge axi_aclk);
        vsync = 1'b1;
        @(negedge axi_aclk);
        vsync = 1'b0;
        repeat (2) @(negedge axi_aclk);
        for (int y = 0; y < int'(v); y++) begin
            for (int x = 0; x < int'(h); x++) begin
                de    = 1'b1;
                pixel = random_pixel();
                exp_pix.push_back(pixel);
                @(negedge axi_aclk);
            end
            de    = 1'b0;
            pixel = '0;
            repeat (3) @(negedge axi_aclk);
        end
    endtask

    // B responses mark each burst's end
    task automatic wait_bursts(input int n);
        while (b_count < n) begin
            @(negedge axi_aclk);
        end
    endtask

    task automatic write_frame(input addr_t base, input dim_t h, input dim_t v, input int done);
        baseaddr = base;
        hactive  = h;
        vactive  = v;
        send_frame(h, v);
        wait_bursts(done + bursts_for(int'(h) * int'(v) / PIXELS_PER_BEAT));
    endtask

    // bursts of BURST_BEATS from base, short tail last, four pixels per beat low first
    task automatic check_frame(input addr_t base, input dim_t h, input dim_t v,
                               input int pix_first, input int burst_first);
        int    beats;
        int    len;
        beat_t exp;
        addr_t a;
        beats = int'(h) * int'(v) / PIXELS_PER_BEAT;
        if (aw_addr_q.size() < burst_first + bursts_for(beats)) begin
            errors++;
            $display("only %0d bursts were issued, frame needs bursts up to %0d",
                     aw_addr_q.size(), burst_first + bursts_for(beats));
            return;
        end
        for (int b = 0; b < bursts_for(beats); b++) begin
            len = beats - b * BURST_BEATS;
            if (len > BURST_BEATS) begin
                len = BURST_BEATS;
            end
            check_addr("awaddr", aw_addr_q[burst_first + b],
                       base + addr_t'(b * BURST_BEATS * BEAT_BYTES));
            check_len("awlen", aw_len_q[burst_first + b], burst_len_t'(len - 1));
        end
        for (int k = 0; k < beats; k++) begin
            for (int s = 0; s < PIXELS_PER_BEAT; s++) begin
                exp[s*PIXEL_W +: PIXEL_W] = exp_pix[pix_first + k * PIXELS_PER_BEAT + s];
            end
            a = base + addr_t'(k * BEAT_BYTES);
            if (!mem.exists(a)) begin
                errors++;
                $display("no beat was written at address 0x%08h", a);
            end else begin
                check_beat("memory beat", mem[a], exp);
            end
        end
    endtask

    task automatic check_burst_count(input int n);
        if (aw_addr_q.size() != n) begin
            errors++;
            $display("%0d bursts were issued where %0d were expected", aw_addr_q.size(), n);
        end
    endtask

    task automatic start_test();
        aw_addr_q.delete();
        aw_len_q.delete();
        mem.delete();
        exp_pix.delete();
        b_count    = 0;
        afull_seen = 1'b0;
        err_mark   = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_mark);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic test_two_bursts();
        start_test();
        write_frame(32'h1000, 16'd16, 16'd4, 0);
        check_frame(32'h1000, 16'd16, 16'd4, 0, 0);
        check_burst_count(2);
        finish_test("test 1, 16x4 frame in two full bursts");
    endtask

    task automatic test_tail_burst();
        start_test();
        write_frame(32'h1000, 16'd12, 16'd3, 0);
        check_frame(32'h1000, 16'd12, 16'd3, 0, 0);
        check_burst_count(2);
        finish_test("test 2, 12x3 frame with one-beat tail");
    endtask

    task automatic test_stalled_bursts();
        start_test();
        stall_on = 1'b1;
        write_frame(32'h1000, 16'd16, 16'd4, 0);
        stall_on = 1'b0;
        check_frame(32'h1000, 16'd16, 16'd4, 0, 0);
        check_burst_count(2);
        finish_test("test 3, 16x4 frame with awready and wready stalls");
    endtask

    task automatic test_refused_frame();
        start_test();
        enable   = 1'b0;
        baseaddr = 32'h5000;
        hactive  = 16'd16;
        vactive  = 16'd4;
        send_frame(16'd16, 16'd4);
        repeat (100) @(negedge axi_aclk);
        if (aw_addr_q.size() != 0) begin
            errors++;
            $display("an AW transfer was issued for a frame sent while disabled");
        end
        enable = 1'b1;
        finish_test("test 4, frame refused with enable low");
    endtask

    task automatic test_back_to_back();
        start_test();
        write_frame(32'h2000, 16'd16, 16'd4, 0);
        write_frame(32'h3000, 16'd12, 16'd3, 2);
        check_frame(32'h2000, 16'd16, 16'd4, 0, 0);
        check_frame(32'h3000, 16'd12, 16'd3, 64, 2);
        check_burst_count(4);
        // both frames are well below FIFO_AFULL beats
        if (afull_seen) begin
            errors++;
            $display("[ERROR] %0t: fifo_almost_full went high during small frames", $time);
        end
        finish_test("test 5, two frames at separate bases");
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset    = 1'b1;
        enable   = 1'b1;
        baseaddr = '0;
        hactive  = '0;
        vactive  = '0;
        vsync    = 1'b0;
        de       = 1'b0;
        pixel    = '0;
        repeat (10) @(negedge axi_aclk);
        reset = 1'b0;
        @(negedge axi_aclk);
        if (awvalid || wvalid || bready || fifo_almost_full) begin
            errors++;
            $display("[ERROR] %0t: bus outputs not idle after reset", $time);
        end
        test_two_bursts();
        test_tail_burst();
        test_stalled_bursts();
        test_refused_frame();
        test_back_to_back();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb.f */
design/vdma_pkg.sv
design/pixel_packer.sv
design/beat_fifo.sv
design/frame_burst_tracker.sv
design/axi_write_fsm.sv
design/vdma_write_top.sv
sim/tb_vdma_write.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_vdma_write -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_vdma_write)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qxF '** PASS **'; then
    exit 0
fi
exit 1
